//--- hdl/motor_pkg.sv
`default_nettype none

package motor_pkg;

    // ==================================================
    // wheel speed
    // ==================================================
    localparam int SPEED_W = 11;

    typedef logic signed [SPEED_W-1:0] speed_t;

    localparam speed_t SPEED_MAX     = 11'sd1023;   // full forward, also reset speed.
    localparam speed_t SPEED_MIN     = -11'sd800;   // hard brake floor.
    localparam speed_t SPEED_ZERO    = 11'sd0;
    localparam speed_t SPEED_REVERSE = -11'sd750;
    localparam speed_t SOFT_FLOOR    = -11'sd100;   // soft brake from standstill.
    localparam speed_t HARD_KNEE     = -11'sd300;   // below this, hard brake jumps to floor.

    // per-frame ramp steps
    localparam speed_t FAST_STEP  = 11'sd23;
    localparam speed_t ACCEL_STEP = 11'sd20;
    localparam speed_t SOFT_STEP  = 11'sd100;
    localparam speed_t HARD_STEP  = 11'sd200;

    // ==================================================
    // duty scaling
    // ==================================================
    localparam int DUTY_DEN = 1024;   // threshold = |speed| * PERIOD / DUTY_DEN.

    // ==================================================
    // sensor pattern and steering actions
    // ==================================================
    typedef logic [2:0] line_mode_t;

    localparam line_mode_t MODE_RESET = 3'b111;   // line centred, full ahead.

    typedef enum logic [2:0] {
        ACT_ACCEL_FAST = 3'd0,
        ACT_ACCEL      = 3'd1,
        ACT_BRAKE_SOFT = 3'd2,
        ACT_BRAKE_HARD = 3'd3,
        ACT_SEARCH     = 3'd4,
        ACT_REVERSE    = 3'd5
    } wheel_action_t;

endpackage

`default_nettype wire

//--- hdl/steer_decode.sv
`timescale 1ns/1ps
`default_nettype none

module steer_decode
    import motor_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  line_mode_t  mode,
    input  wire logic   frame_end,
    output wheel_action_t left_action,
    output wheel_action_t right_action
);

    line_mode_t prev_mode;       // last frame-end sample.
    line_mode_t accepted_mode;   // pattern seen on two frame ends in a row.

    // ==================================================
    // two-frame stability filter
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_mode     <= MODE_RESET;
            accepted_mode <= MODE_RESET;
        end else if (frame_end) begin
            prev_mode <= mode;
            if (mode == prev_mode) begin
                accepted_mode <= mode;   // stable for two samples.
            end
        end
    end

    // ==================================================
    // pattern to per-wheel action
    // ==================================================
    always_comb begin
        case (accepted_mode)
            3'b111: begin
                left_action  = ACT_ACCEL_FAST;
                right_action = ACT_ACCEL_FAST;
            end
            3'b110: begin
                left_action  = ACT_BRAKE_SOFT;   // drifting left.
                right_action = ACT_ACCEL;
            end
            3'b100: begin
                left_action  = ACT_BRAKE_HARD;
                right_action = ACT_ACCEL;
            end
            3'b011: begin
                left_action  = ACT_ACCEL;        // drifting right.
                right_action = ACT_BRAKE_SOFT;
            end
            3'b001: begin
                left_action  = ACT_ACCEL;
                right_action = ACT_BRAKE_HARD;
            end
            3'b000: begin
                left_action  = ACT_SEARCH;       // line lost.
                right_action = ACT_SEARCH;
            end
            default: begin
                // 010 and 101 cannot come from a single line, so back off.
                left_action  = ACT_REVERSE;
                right_action = ACT_REVERSE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/wheel_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module wheel_ramp
    import motor_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    frame_end,
    input  wheel_action_t left_action,
    input  wheel_action_t right_action,
    output speed_t        left_speed,
    output speed_t        right_speed
);

    speed_t left_next;
    speed_t right_next;
    logic   left_leads;   // left strictly faster, used by search.

    // ==================================================
    // ramp rules for one wheel
    // ==================================================
    function automatic speed_t ramp_speed(
        input wheel_action_t act,
        input speed_t        s,
        input logic          lead
    );
        speed_t nxt;
        case (act)
            ACT_ACCEL_FAST: begin
                nxt = (s > SPEED_MAX - FAST_STEP) ? SPEED_MAX : s + FAST_STEP;
            end
            ACT_ACCEL: begin
                nxt = (s > SPEED_MAX - ACCEL_STEP) ? SPEED_MAX : s + ACCEL_STEP;
            end
            ACT_BRAKE_SOFT: begin
                nxt = (s > SPEED_ZERO) ? s - SOFT_STEP : SOFT_FLOOR;
            end
            ACT_BRAKE_HARD: begin
                nxt = (s > HARD_KNEE) ? s - HARD_STEP : SPEED_MIN;
            end
            ACT_SEARCH: begin
                nxt = lead ? SPEED_MAX : SPEED_ZERO;   // spin toward faster side.
            end
            ACT_REVERSE: begin
                nxt = SPEED_REVERSE;
            end
            default: begin
                nxt = s;   // unused encodings hold.
            end
        endcase
        return nxt;
    endfunction

    // ==================================================
    // next speeds
    // ==================================================
    assign left_leads = (left_speed > right_speed);

    // tie goes to the right wheel.
    assign left_next  = ramp_speed(left_action, left_speed, left_leads);
    assign right_next = ramp_speed(right_action, right_speed, !left_leads);

    // ==================================================
    // speed registers, updated once per frame
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_speed  <= SPEED_MAX;
            right_speed <= SPEED_MAX;
        end else if (frame_end) begin
            left_speed  <= left_next;
            right_speed <= right_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pwm_frame.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_frame
    import motor_pkg::*;
#(
    parameter int unsigned PERIOD = 4000
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  speed_t     left_speed,
    input  speed_t     right_speed,
    output logic       frame_end,
    output logic [1:0] pwm,
    output logic [1:0] dir
);

    localparam int CNT_W  = $clog2(PERIOD);
    localparam int MAG_W  = SPEED_W - 1;      // magnitude never exceeds 1023.
    localparam int PROD_W = MAG_W + CNT_W;    // holds |speed| * PERIOD.

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] left_thr;
    logic [CNT_W-1:0] right_thr;

    // ==================================================
    // magnitude to duty threshold
    // ==================================================
    function automatic logic [CNT_W-1:0] duty_threshold(input speed_t s);
        speed_t            neg;
        logic [MAG_W-1:0]  mag;
        logic [PROD_W-1:0] prod;
        neg  = -s;
        mag  = s[SPEED_W-1] ? neg[MAG_W-1:0] : s[MAG_W-1:0];
        prod = PROD_W'(mag) * PROD_W'(PERIOD);
        // always below PERIOD, so it fits the count width.
        return CNT_W'(prod / PROD_W'(DUTY_DEN));
    endfunction

    // ==================================================
    // frame counter
    // ==================================================
    assign frame_end = (count == CNT_W'(PERIOD - 1));   // last cycle of the frame.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (frame_end) begin
            count <= '0;   // wraps with the speed update.
        end else begin
            count <= count + 1'b1;
        end
    end

    // ==================================================
    // pwm outputs
    // ==================================================
    assign left_thr  = duty_threshold(left_speed);
    assign right_thr = duty_threshold(right_speed);

    // registered compare, so the high run starts one cycle into the frame.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm <= 2'b00;
        end else begin
            pwm[1] <= (count < left_thr);
            pwm[0] <= (count < right_thr);
        end
    end

    // sign bit, 1 is backward.
    assign dir = {left_speed[SPEED_W-1], right_speed[SPEED_W-1]};

endmodule

`default_nettype wire

//--- hdl/motor_drive.sv
`timescale 1ns/1ps
`default_nettype none

module motor_drive
    import motor_pkg::*;
#(
    parameter int unsigned PERIOD = 4000   // clk cycles per pwm frame.
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  line_mode_t mode,
    output logic [1:0] pwm,     // [1] left, [0] right.
    output logic [1:0] dir      // [1] left, [0] right.
);

    logic          frame_end;
    wheel_action_t left_action;
    wheel_action_t right_action;
    speed_t        left_speed;
    speed_t        right_speed;

    // ==================================================
    // decode
    // ==================================================
    steer_decode steer_decode_inst (
        .clk          (clk),
        .reset        (reset),
        .mode         (mode),
        .frame_end    (frame_end),
        .left_action  (left_action),
        .right_action (right_action)
    );

    // ==================================================
    // execute
    // ==================================================
    wheel_ramp wheel_ramp_inst (
        .clk          (clk),
        .reset        (reset),
        .frame_end    (frame_end),
        .left_action  (left_action),
        .right_action (right_action),
        .left_speed   (left_speed),
        .right_speed  (right_speed)
    );

    // ==================================================
    // result
    // ==================================================
    pwm_frame #(
        .PERIOD (PERIOD)
    ) pwm_frame_inst (
        .clk         (clk),
        .reset       (reset),
        .left_speed  (left_speed),
        .right_speed (right_speed),
        .frame_end   (frame_end),
        .pwm         (pwm),
        .dir         (dir)
    );

endmodule

`default_nettype wire

//--- testbench/tb_motor_model.svh
`ifndef TB_MOTOR_MODEL_SVH
`define TB_MOTOR_MODEL_SVH

// ==================================================
// reference model of filter, actions and ramp
// ==================================================
line_mode_t prev_mode_exp;
line_mode_t accepted_mode_exp;
int         left_speed_exp;
int         right_speed_exp;

task automatic reset_model();
    prev_mode_exp     = 3'b111;
    accepted_mode_exp = 3'b111;
    left_speed_exp    = 1023;
    right_speed_exp   = 1023;
endtask

task automatic actions_for_mode(input line_mode_t m, output wheel_action_t la,
                                output wheel_action_t ra);
    case (m)
        3'b111: begin la = ACT_ACCEL_FAST; ra = ACT_ACCEL_FAST; end
        3'b110: begin la = ACT_BRAKE_SOFT; ra = ACT_ACCEL;      end
        3'b100: begin la = ACT_BRAKE_HARD; ra = ACT_ACCEL;      end
        3'b011: begin la = ACT_ACCEL;      ra = ACT_BRAKE_SOFT; end
        3'b001: begin la = ACT_ACCEL;      ra = ACT_BRAKE_HARD; end
        3'b000: begin la = ACT_SEARCH;     ra = ACT_SEARCH;     end
        default: begin la = ACT_REVERSE;   ra = ACT_REVERSE;    end
    endcase
endtask

function automatic int ramp_next(input wheel_action_t act, input int s, input bit lead);
    case (act)
        ACT_ACCEL_FAST: return (s > 1000) ? 1023 : s + 23;
        ACT_ACCEL:      return (s > 1003) ? 1023 : s + 20;
        ACT_BRAKE_SOFT: return (s > 0) ? s - 100 : -100;
        ACT_BRAKE_HARD: return (s > -300) ? s - 200 : -800;
        ACT_SEARCH:     return lead ? 1023 : 0;
        default:        return -750;   // reverse.
    endcase
endfunction

function automatic int unsigned duty_for_speed(input int s);
    int mag;
    mag = (s < 0) ? -s : s;
    return int'(mag * PERIOD / 1024);
endfunction

// speeds move on the old accepted mode, then the filter takes the sample.
task automatic update_at_frame_end(input line_mode_t sampled);
    wheel_action_t la;
    wheel_action_t ra;
    bit            left_leads;
    int            left_new;
    int            right_new;
    actions_for_mode(accepted_mode_exp, la, ra);
    left_leads      = (left_speed_exp > right_speed_exp);
    left_new        = ramp_next(la, left_speed_exp, left_leads);
    right_new       = ramp_next(ra, right_speed_exp, !left_leads);   // tie to the right.
    left_speed_exp  = left_new;
    right_speed_exp = right_new;
    if (sampled == prev_mode_exp) begin
        accepted_mode_exp = sampled;
    end
    prev_mode_exp = sampled;
endtask

`endif

//--- testbench/tb_motor_drive.sv
`timescale 1ns/1ps
`default_nettype none

module tb_motor_drive
    import motor_pkg::*;
();

    localparam int PERIOD       = 64;
    localparam int FRAMES       = 400;
    localparam int RESET_CYCLES = 5;
    localparam int HOLD_FRAMES  = 4;   // straight line first.
    localparam int RUN_LIMIT    = (FRAMES + 8) * PERIOD + RESET_CYCLES;

    logic        clk;
    logic        reset;
    line_mode_t  mode;
    logic [1:0]  pwm;
    logic [1:0]  dir;
    logic [31:0] lfsr_state;

    `include "tb_motor_model.svh"

    motor_drive #(
        .PERIOD (PERIOD)
    ) motor_drive_inst (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .pwm   (pwm),
        .dir   (dir)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // random bits and checks
    // ==================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // taps 32, 22, 2, 1.
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare_level(input string name, input logic [1:0] expected,
                                 input logic [1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "output level mismatch");
        end
    endtask

    task automatic compare_speed_dir(input string name, input speed_t expected_speed,
                                     input logic actual);
        logic expected;
        expected = (expected_speed < 0);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "direction mismatch");
        end
    endtask

    task automatic compare_duty(input string name, input int unsigned expected,
                                input int unsigned actual);
        if (actual != expected) begin
            $display("[ERROR] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "duty mismatch");
        end
    endtask

    task automatic tally_pwm(input string name, input logic level,
                             inout int unsigned high, inout bit seen_low);
        if (level !== 1'b1) begin
            seen_low = 1'b1;
        end else if (seen_low) begin
            $display("%s went high again after a low cycle in one frame at t=%0t", name, $time);
            $display("Something failed");
            $fatal(1, "pwm run not contiguous");
        end else begin
            high++;
        end
    endtask

    // ==================================================
    // stimulus and per-frame checking
    // ==================================================
    initial begin
        int unsigned high_left;
        int unsigned high_right;
        int unsigned thr_left;
        int unsigned thr_right;
        bit          low_left;
        bit          low_right;
        int          pos;
        int          frame;
        int          pick;
        int          change_pos;
        line_mode_t  next_mode;

        lfsr_state = 32'h09e2_9e8c;
        reset      = 1'b1;
        mode       = 3'b111;
        reset_model();
        high_left  = 0;
        high_right = 0;
        thr_left   = 0;
        thr_right  = 0;
        low_left   = 1'b0;
        low_right  = 1'b0;
        change_pos = -1;
        next_mode  = 3'b111;

        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge clk);
            @(negedge clk);
            compare_level("pwm", 2'b00, pwm);
            compare_level("dir", 2'b00, dir);
        end
        @(posedge clk);
        reset <= 1'b0;   // frame 0 starts here.

        for (int i = 0; i <= FRAMES * PERIOD; i++) begin
            frame = i / PERIOD;
            pos   = i % PERIOD;
            if (pos == 0) begin
                take_bits(3, pick);
                if (frame < HOLD_FRAMES || pick < 5) begin
                    change_pos = -1;   // hold.
                end else begin
                    take_bits(3, pick);
                    next_mode = line_mode_t'(pick);
                    take_bits(6, change_pos);
                end
            end
            if (pos == change_pos) begin
                mode <= next_mode;
            end
            @(negedge clk);
            // window of a frame is shifted one cycle by the pwm register.
            if (i > 0) begin
                tally_pwm("pwm[1]", pwm[1], high_left, low_left);
                tally_pwm("pwm[0]", pwm[0], high_right, low_right);
            end
            if (pos == 0 && frame > 0) begin
                compare_duty("pwm[1] high count", thr_left, high_left);
                compare_duty("pwm[0] high count", thr_right, high_right);
                high_left  = 0;
                high_right = 0;
                low_left   = 1'b0;
                low_right  = 1'b0;
            end
            compare_speed_dir("dir[1]", speed_t'(left_speed_exp), dir[1]);
            compare_speed_dir("dir[0]", speed_t'(right_speed_exp), dir[0]);
            if (pos == PERIOD - 1) begin
                thr_left  = duty_for_speed(left_speed_exp);
                thr_right = duty_for_speed(right_speed_exp);
                update_at_frame_end(mode);   // value seen at the frame end.
            end
            @(posedge clk);
        end

        $display("Everything OK");
        $finish;
    end

    // watchdog.
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
        $display("Something failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+testbench
hdl/motor_pkg.sv
hdl/steer_decode.sv
hdl/wheel_ramp.sv
hdl/pwm_frame.sv
hdl/motor_drive.sv
testbench/tb_motor_drive.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the motor driver testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sim.f \
    --top-module tb_motor_drive \
    -o tb_motor_drive

# The simulator exits nonzero on failure, so keep its output for the search below.
sim_output=$(./obj_dir/tb_motor_drive 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "Everything OK"; then
    exit 0
else
    exit 1
fi
